// ==== rtl/holo_pkg.sv ====
`default_nettype none

package holo_pkg;

  // one uart or spi byte
  typedef logic [7:0] byte_t;

  // address byte in [15:8], data byte in [7:0]
  typedef logic [15:0] spi_word_t;

  // shared by receiver and transmitter
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  // spi master sequencing
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_FINISH
  } spi_state_e;

  // fpga_clk cycles per uart bit
  localparam int DEF_CLKS_PER_BIT = 20;
  // fpga_clk cycles per half sclk period
  localparam int DEF_SPI_HALF_DIV = 4;
  // reply queue entries, power of two
  localparam int DEF_FIFO_DEPTH = 4;
  // display reset stretch in cycles
  localparam int DEF_RESET_CYCLES = 10;

endpackage

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = holo_pkg::DEF_CLKS_PER_BIT
) (
  input  wire logic       fpga_clk,
  input  wire logic       reset_all_cmd_w,
  input  wire logic       rx_serial_i,
  output logic            rx_valid_o,
  output holo_pkg::byte_t rx_byte_o
);
  import holo_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  // last count of a full bit, and the start bit midpoint
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] BIT_MID  = CNT_W'((CLKS_PER_BIT - 1) / 2);

  logic             rx_meta;
  logic             rx_sync;
  uart_state_e      state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;

  // two flop synchronizer, line idles high
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_serial_i;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state      <= UART_IDLE;
      clk_cnt    <= '0;
      bit_idx    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // falling edge marks a possible start bit
          if (!rx_sync) begin
            state <= UART_START;
          end
        end
        UART_START: begin
          if (clk_cnt == BIT_MID) begin
            clk_cnt <= '0;
            // line back high at midpoint, glitch
            state   <= rx_sync ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= UART_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          // mid stop bit, byte complete
          if (clk_cnt == BIT_LAST) begin
            clk_cnt    <= '0;
            rx_valid_o <= 1'b1;
            state      <= UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  // lsb first, sampled at each data bit midpoint
  always_ff @(posedge fpga_clk) begin
    if (state == UART_DATA && clk_cnt == BIT_LAST) begin
      rx_byte_o <= {rx_sync, rx_byte_o[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = holo_pkg::DEF_CLKS_PER_BIT
) (
  input  wire logic            fpga_clk,
  input  wire logic            reset_all_cmd_w,
  input  wire logic            send_i,
  input  wire holo_pkg::byte_t send_byte_i,
  output logic                 tx_serial_o,
  output logic                 tx_busy_o
);
  import holo_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  uart_state_e      state;
  logic [CNT_W-1:0] clk_cnt;
  logic [2:0]       bit_idx;
  byte_t            tx_data;
  logic             bit_done;

  assign bit_done = (clk_cnt == BIT_LAST);

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state       <= UART_IDLE;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      tx_serial_o <= 1'b1;
      tx_busy_o   <= 1'b0;
    end else begin
      case (state)
        UART_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          // start bit goes out the next cycle
          if (send_i) begin
            tx_serial_o <= 1'b0;
            tx_busy_o   <= 1'b1;
            state       <= UART_START;
          end
        end
        UART_START: begin
          if (bit_done) begin
            clk_cnt     <= '0;
            tx_serial_o <= tx_data[0];
            state       <= UART_DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_DATA: begin
          if (bit_done) begin
            clk_cnt <= '0;
            if (bit_idx == 3'd7) begin
              tx_serial_o <= 1'b1;
              state       <= UART_STOP;
            end else begin
              bit_idx     <= bit_idx + 1'b1;
              tx_serial_o <= tx_data[bit_idx + 3'd1];
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        UART_STOP: begin
          // busy drops only once stop bit is complete
          if (bit_done) begin
            clk_cnt   <= '0;
            tx_busy_o <= 1'b0;
            state     <= UART_IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  // byte latched at launch
  always_ff @(posedge fpga_clk) begin
    if (state == UART_IDLE && send_i) begin
      tx_data <= send_byte_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cmd_pairer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_pairer (
  input  wire logic            fpga_clk,
  input  wire logic            reset_all_cmd_w,
  input  wire logic            rx_valid_i,
  input  wire holo_pkg::byte_t rx_byte_i,
  output logic                 spi_start_o,
  output holo_pkg::spi_word_t  spi_word_o
);

  // high once the address byte of a pair is held
  logic have_addr;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      have_addr   <= 1'b0;
      spi_start_o <= 1'b0;
    end else begin
      // second byte of a pair launches the transfer
      spi_start_o <= rx_valid_i && have_addr;
      if (rx_valid_i) begin
        have_addr <= ~have_addr;
      end
    end
  end

  // old data byte moves up into the address half
  // new byte lands in the data half
  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i) begin
      spi_word_o <= {spi_word_o[7:0], rx_byte_i};
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
  parameter int SPI_HALF_DIV = holo_pkg::DEF_SPI_HALF_DIV
) (
  input  wire logic                fpga_clk,
  input  wire logic                reset_all_cmd_w,
  input  wire logic                start_i,
  input  wire holo_pkg::spi_word_t word_i,
  input  wire logic                miso_i,
  output logic                     sen_o,
  output logic                     sck_o,
  output logic                     mosi_o,
  output logic                     reply_valid_o,
  output holo_pkg::byte_t          reply_byte_o
);
  import holo_pkg::*;

  localparam int DIV_W = (SPI_HALF_DIV > 1) ? $clog2(SPI_HALF_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_HALF_DIV - 1);

  spi_state_e       state;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_cnt;
  spi_word_t        tx_shift;
  byte_t            rx_shift;
  logic             load;
  logic             half_done;
  logic             sck_rise;
  logic             sck_fall;

  ////////////////////////////////////////////////////////////
  // edge strobes
  ////////////////////////////////////////////////////////////
  assign load      = (state == SPI_IDLE) && start_i;
  assign half_done = (state == SPI_SHIFT) && (div_cnt == DIV_LAST);
  // sck about to rise so miso gets sampled
  assign sck_rise  = half_done && !sck_o;
  // sck about to fall and the next mosi bit goes out
  assign sck_fall  = half_done && sck_o;

  ////////////////////////////////////////////////////////////
  // control fsm for mode 0
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state         <= SPI_IDLE;
      div_cnt       <= '0;
      bit_cnt       <= '0;
      sen_o         <= 1'b1;
      sck_o         <= 1'b0;
      mosi_o        <= 1'b0;
      reply_valid_o <= 1'b0;
    end else begin
      reply_valid_o <= 1'b0;
      case (state)
        SPI_IDLE: begin
          // msb ready on mosi as chip select drops
          if (start_i) begin
            sen_o   <= 1'b0;
            mosi_o  <= word_i[15];
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_done) begin
            div_cnt <= '0;
            sck_o   <= ~sck_o;
            if (sck_o) begin
              if (bit_cnt == 4'd15) begin
                // last falling edge ends the transfer
                sen_o         <= 1'b1;
                mosi_o        <= 1'b0;
                reply_valid_o <= 1'b1;
                state         <= SPI_FINISH;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
                mosi_o  <= tx_shift[14];
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        // one cycle of chip select high before next start
        SPI_FINISH: state <= SPI_IDLE;
        default:    state <= SPI_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (load) begin
      tx_shift <= word_i;
    end else if (sck_fall) begin
      tx_shift <= {tx_shift[14:0], 1'b0};
    end
    if (sck_rise) begin
      rx_shift <= {rx_shift[6:0], miso_i};
    end
  end

  // last eight bits sampled and held until the next transfer
  assign reply_byte_o = rx_shift;

endmodule

`default_nettype wire

// ==== rtl/resp_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_fifo #(
  parameter int FIFO_DEPTH = holo_pkg::DEF_FIFO_DEPTH
) (
  input  wire logic            fpga_clk,
  input  wire logic            reset_all_cmd_w,
  input  wire logic            push_i,
  input  wire holo_pkg::byte_t push_byte_i,
  input  wire logic            tx_busy_i,
  output logic                 send_o,
  output holo_pkg::byte_t      send_byte_o
);
  import holo_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

  byte_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             holdoff;
  logic             do_push;
  logic             do_pop;

  // replies arriving while full are lost
  assign do_push = push_i && (count != FULL_CNT);
  // holdoff gives tx_busy a cycle to rise after a launch
  assign do_pop  = (count != '0) && !tx_busy_i && !holdoff;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      holdoff <= 1'b0;
      send_o  <= 1'b0;
    end else begin
      send_o  <= do_pop;
      holdoff <= do_pop;
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage and launch byte
  always_ff @(posedge fpga_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_byte_i;
    end
    if (do_pop) begin
      send_byte_o <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/slm_reset_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module slm_reset_gen #(
  parameter int RESET_CYCLES = holo_pkg::DEF_RESET_CYCLES
) (
  input  wire logic fpga_clk,
  input  wire logic reset_all_cmd_w,
  output logic      slm_reset_n_o
);

  localparam int CNT_W = $clog2(RESET_CYCLES + 1);

  logic [CNT_W-1:0] stretch_cnt;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // reload, hold display in reset
      stretch_cnt   <= CNT_W'(RESET_CYCLES);
      slm_reset_n_o <= 1'b0;
    end else begin
      if (stretch_cnt != '0) begin
        stretch_cnt <= stretch_cnt - 1'b1;
      end
      // release only after the count has run out
      slm_reset_n_o <= (stretch_cnt == '0);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/holo_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module holo_bridge_top #(
  parameter int CLKS_PER_BIT = holo_pkg::DEF_CLKS_PER_BIT,
  parameter int SPI_HALF_DIV = holo_pkg::DEF_SPI_HALF_DIV,
  parameter int FIFO_DEPTH   = holo_pkg::DEF_FIFO_DEPTH,
  parameter int RESET_CYCLES = holo_pkg::DEF_RESET_CYCLES
) (
  input  wire logic fpga_clk,
  input  wire logic reset_all_cmd_w,
  input  wire logic uart_rx_i,
  input  wire logic sout_i,
  output logic      uart_tx_o,
  output logic      sen_o,
  output logic      sck_o,
  output logic      sdat_o,
  output logic      slm_reset_n_o
);
  import holo_pkg::*;

  ////////////////////////////////////////////////////////////
  // host to display path
  ////////////////////////////////////////////////////////////
  logic      rx_valid;
  byte_t     rx_byte;
  logic      spi_start;
  spi_word_t spi_word;

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  // address then data byte per transfer
  cmd_pairer u_cmd_pairer (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_start_o     (spi_start),
    .spi_word_o      (spi_word)
  );

  ////////////////////////////////////////////////////////////
  // display to host path
  ////////////////////////////////////////////////////////////
  logic  reply_valid;
  byte_t reply_byte;
  logic  send;
  byte_t send_byte;
  logic  tx_busy;

  spi_master #(.SPI_HALF_DIV(SPI_HALF_DIV)) u_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .start_i         (spi_start),
    .word_i          (spi_word),
    .miso_i          (sout_i),
    .sen_o           (sen_o),
    .sck_o           (sck_o),
    .mosi_o          (sdat_o),
    .reply_valid_o   (reply_valid),
    .reply_byte_o    (reply_byte)
  );

  resp_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_resp_fifo (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .push_i          (reply_valid),
    .push_byte_i     (reply_byte),
    .tx_busy_i       (tx_busy),
    .send_o          (send),
    .send_byte_o     (send_byte)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .send_i          (send),
    .send_byte_i     (send_byte),
    .tx_serial_o     (uart_tx_o),
    .tx_busy_o       (tx_busy)
  );

  // display reset, active low
  slm_reset_gen #(.RESET_CYCLES(RESET_CYCLES)) u_slm_reset_gen (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_holo_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_holo_bridge;
  import holo_pkg::*;

  localparam int CLKS_PER_BIT = DEF_CLKS_PER_BIT;
  localparam int SPI_HALF_DIV = DEF_SPI_HALF_DIV;
  localparam int FIFO_DEPTH   = DEF_FIFO_DEPTH;
  localparam int RESET_CYCLES = DEF_RESET_CYCLES;
  localparam int RAND_PAIRS   = 30;
  localparam int BURST_PAIRS  = 8;
  // random pairs plus the lone byte pair and the burst
  localparam int TOTAL_PAIRS  = RAND_PAIRS + 1 + BURST_PAIRS;
  localparam int TIMEOUT_CYCLES = (TOTAL_PAIRS * 40 + 200) * CLKS_PER_BIT;

  logic fpga_clk = 1'b0;
  logic reset_all_cmd_w;
  logic uart_rx_line;
  logic sout;
  logic uart_tx_line;
  logic sen;
  logic sck;
  logic sdat;
  logic slm_reset_n;

  // scoreboard queues
  logic [15:0] exp_words[$];
  logic [7:0]  exp_replies[$];

  int fail_cnt    = 0;
  int cycle_cnt   = 0;
  int xfer_starts = 0;
  int xfer_cnt    = 0;
  int reply_cnt   = 0;

  // spi slave model state
  logic        prev_sen = 1'b1;
  logic        prev_sck = 1'b0;
  logic [15:0] slave_reply;
  logic [15:0] mosi_word;
  int          bit_pos;
  int          rise_cnt;

  holo_bridge_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .SPI_HALF_DIV (SPI_HALF_DIV),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .RESET_CYCLES (RESET_CYCLES)
  ) dut0 (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_line),
    .sout_i          (sout),
    .uart_tx_o       (uart_tx_line),
    .sen_o           (sen),
    .sck_o           (sck),
    .sdat_o          (sdat),
    .slm_reset_n_o   (slm_reset_n)
  );

  // 8 ns period
  always #4 fpga_clk = ~fpga_clk;

  ////////////////////////////////////////////////////////////
  // error handling
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string msg);
    fail_cnt++;
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h",
                          $time, name, exp, act));
    end
  endtask

  // run limit
  always @(posedge fpga_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("timeout: replies did not all come back within the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////
  // uart host model
  ////////////////////////////////////////////////////////////
  task automatic wait_bits(input int n);
    repeat (n * CLKS_PER_BIT) @(negedge fpga_clk);
  endtask

  // start bit then lsb first data then stop bit
  task automatic uart_send_byte(input logic [7:0] b);
    uart_rx_line = 1'b0;
    wait_bits(1);
    for (int i = 0; i < 8; i++) begin
      uart_rx_line = b[i];
      wait_bits(1);
    end
    uart_rx_line = 1'b1;
    wait_bits(1);
  endtask

  // first byte is the address and the second the data
  task automatic send_pair(input logic [7:0] a, input logic [7:0] d, input int gap);
    exp_words.push_back({a, d});
    uart_send_byte(a);
    wait_bits(gap);
    uart_send_byte(d);
  endtask

  ////////////////////////////////////////////////////////////
  // spi slave model in mode 0
  ////////////////////////////////////////////////////////////
  always @(negedge fpga_clk) begin
    if (!reset_all_cmd_w) begin
      // new random reply when chip select falls
      if (prev_sen === 1'b1 && sen === 1'b0) begin
        slave_reply = 16'($urandom());
        bit_pos     = 15;
        rise_cnt    = 0;
        mosi_word   = '0;
        sout        = slave_reply[15];
        xfer_starts++;
      end
      // mosi captured on rising sclk
      if (sen === 1'b0 && prev_sck === 1'b0 && sck === 1'b1) begin
        mosi_word = {mosi_word[14:0], sdat};
        rise_cnt++;
      end
      // next miso bit on falling sclk
      if (sen === 1'b0 && prev_sck === 1'b1 && sck === 1'b0 && bit_pos > 0) begin
        bit_pos--;
        sout = slave_reply[bit_pos];
      end
      // chip select rising ends the transfer
      if (prev_sen === 1'b0 && sen === 1'b1) begin
        if (exp_words.size() == 0) begin
          abort_run("an SPI transfer happened with no complete byte pair sent");
        end
        check_value("sck_o rising edges", 32'd16, rise_cnt);
        check_value("sdat_o word", exp_words.pop_front(), mosi_word);
        exp_replies.push_back(slave_reply[7:0]);
        xfer_cnt++;
      end
      prev_sen = sen;
      prev_sck = sck;
    end
  end

  ////////////////////////////////////////////////////////////
  // uart monitor on uart_tx_o
  ////////////////////////////////////////////////////////////
  initial begin : uart_monitor
    logic [7:0] got;
    wait (reset_all_cmd_w === 1'b0);
    @(negedge fpga_clk);
    forever begin
      while (uart_tx_line !== 1'b0) begin
        @(negedge fpga_clk);
      end
      // move to the middle of the start bit
      repeat (CLKS_PER_BIT / 2) @(negedge fpga_clk);
      if (uart_tx_line !== 1'b0) begin
        abort_run("start bit on uart_tx_o did not last half a bit");
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge fpga_clk);
        got[i] = uart_tx_line;
      end
      repeat (CLKS_PER_BIT) @(negedge fpga_clk);
      if (uart_tx_line !== 1'b1) begin
        abort_run("stop bit missing on uart_tx_o");
      end
      if (exp_replies.size() == 0) begin
        abort_run("a reply byte came back with no SPI transfer behind it");
      end
      check_value("uart_tx_o byte", exp_replies.pop_front(), got);
      reply_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    int unsigned seed_var;
    int unsigned dummy;
    int          low_cnt;
    int          starts_before;
    logic [7:0]  lone_byte;
    logic [7:0]  partner_byte;

    seed_var        = 32'h59f57a25;
    dummy           = $urandom(seed_var);
    reset_all_cmd_w = 1'b1;
    uart_rx_line    = 1'b1;
    sout            = 1'b0;
    repeat (2) @(posedge fpga_clk);
    @(negedge fpga_clk);
    reset_all_cmd_w = 1'b0;

    // idle levels and the display reset stretch
    @(negedge fpga_clk);
    check_value("uart_tx_o after reset", 32'd1, uart_tx_line);
    check_value("sen_o after reset", 32'd1, sen);
    check_value("sck_o after reset", 32'd0, sck);
    check_value("sdat_o after reset", 32'd0, sdat);
    low_cnt = 0;
    while (slm_reset_n !== 1'b1 && low_cnt <= RESET_CYCLES + 4) begin
      low_cnt++;
      @(negedge fpga_clk);
    end
    check_value("slm_reset_n_o low cycles", RESET_CYCLES, low_cnt);
    repeat (4) begin
      @(negedge fpga_clk);
      check_value("slm_reset_n_o after stretch", 32'd1, slm_reset_n);
    end

    // random pairs with small random gaps
    for (int p = 0; p < RAND_PAIRS; p++) begin
      send_pair(8'($urandom()), 8'($urandom()), $urandom_range(2, 0));
      wait_bits($urandom_range(4, 0));
    end

    // a lone byte waits for its partner
    lone_byte     = 8'($urandom());
    partner_byte  = 8'($urandom());
    starts_before = xfer_starts;
    uart_send_byte(lone_byte);
    wait_bits(40);
    check_value("spi transfers after lone byte", starts_before, xfer_starts);
    // partner byte completes the held pair
    exp_words.push_back({lone_byte, partner_byte});
    uart_send_byte(partner_byte);

    // back to back with no idle between frames
    for (int p = 0; p < BURST_PAIRS; p++) begin
      send_pair(8'($urandom()), 8'($urandom()), 0);
    end

    // drain and then make sure nothing extra shows up
    while (reply_cnt < TOTAL_PAIRS) begin
      @(negedge fpga_clk);
    end
    wait_bits(30);
    check_value("spi transfer count", TOTAL_PAIRS, xfer_cnt);
    check_value("reply byte count", TOTAL_PAIRS, reply_cnt);
    check_value("words left unmatched", 32'd0, exp_words.size());
    check_value("replies left unmatched", 32'd0, exp_replies.size());

    if (fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/holo_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_pairer.sv
rtl/spi_master.sv
rtl/resp_fifo.sv
rtl/slm_reset_gen.sv
rtl/holo_bridge_top.sv
bench/tb_holo_bridge.sv
